//--- sources.f
logic/isa_pkg.sv
logic/cluster_pkg.sv
logic/issue_queue.sv
logic/alu_unit.sv
logic/complete_arbiter.sv
logic/phys_regfile.sv
logic/exec_cluster.sv
testbench/exec_cluster_tb.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  - logic/isa_pkg.sv
  - logic/cluster_pkg.sv
  - logic/issue_queue.sv
  - logic/alu_unit.sv
  - logic/complete_arbiter.sv
  - logic/phys_regfile.sv
  - logic/exec_cluster.sv
  - target: simulation
    files:
      - testbench/exec_cluster_tb.sv

//--- testbench/exec_cluster_tb.sv
`timescale 1ns/1ns

module exec_cluster_tb
    import isa_pkg::*;
    import cluster_pkg::*;
();

    // 8 single ops, 4 handshake ops, 24 burst ops.
    localparam int total_ops = 8 + 4 + 24;
    localparam int watchdog_cycles = total_ops * 40 + 200;
    localparam int num_tags = 64;
    localparam int burst_len = 24;
    localparam int burst_base = 16;

    logic     clk;
    logic     rstn;
    logic     dispatch_req;
    optype_t  dispatch_op;
    word_t    dispatch_src1;
    word_t    dispatch_src2;
    ptag_t    dispatch_tag;
    rob_num_t dispatch_rob;
    ptag_t    rd_tag;
    logic     dispatch_ack;
    logic     cpl_valid;
    ptag_t    cpl_tag;
    rob_num_t cpl_rob;
    word_t    cpl_data;
    word_t    rd_data;

    // expected results, filled at dispatch.
    word_t    exp_data  [num_tags];
    rob_num_t exp_rob   [num_tags];
    int       ack_cycle [num_tags];

    // observed completions, filled by the monitor.
    int       seen_cnt  [num_tags];
    word_t    got_data  [num_tags];
    rob_num_t got_rob   [num_tags];
    int       got_cycle [num_tags];
    int       cpl_total;
    int       ack_rises;

    int          cycle;
    logic        cpl_prev;
    logic        ack_prev;
    logic        req_prev;
    logic [31:0] seed = 32'h30a6;

    exec_cluster UUT (
        .clk(clk),
        .rstn(rstn),
        .dispatch_req(dispatch_req),
        .dispatch_op(dispatch_op),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_tag(dispatch_tag),
        .dispatch_rob(dispatch_rob),
        .rd_tag(rd_tag),
        .dispatch_ack(dispatch_ack),
        .cpl_valid(cpl_valid),
        .cpl_tag(cpl_tag),
        .cpl_rob(cpl_rob),
        .cpl_data(cpl_data),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
    end

    task automatic fail_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("FAILED %s: expected 0x%08h, actual 0x%08h", what, expected, actual);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_text(input string what);
        $display("ERROR: %s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // lcg step, numerical recipes constants.
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // expected result per operation rule.
    function automatic word_t ref_result(input optype_t op, input word_t a, input word_t b);
        case (op)
            op_add: return a + b;
            op_sub: return a - b;
            op_and: return a & b;
            op_or:  return a | b;
            op_xor: return a ^ b;
            op_sll: return a << b[4:0];
            op_srl: return a >> b[4:0];
            op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // completion and dispatch handshake monitor.
    // sampled at the falling edge, away from the driven edges.
    always @(negedge clk) begin
        if (rstn) begin
            if (cpl_valid) begin
                assert (!cpl_prev)
                else fail_text("cpl_valid stayed high for two cycles");
                seen_cnt[cpl_tag] = seen_cnt[cpl_tag] + 1;
                got_data[cpl_tag] = cpl_data;
                got_rob[cpl_tag] = cpl_rob;
                got_cycle[cpl_tag] = cycle;
                cpl_total = cpl_total + 1;
            end
            // req_prev is what the queue saw at the last edge.
            if (dispatch_ack && !ack_prev) begin
                assert (req_prev)
                else fail_text("dispatch_ack rose while dispatch_req was low");
                ack_rises = ack_rises + 1;
            end
            if (!dispatch_ack && ack_prev) begin
                assert (!req_prev)
                else fail_text("dispatch_ack fell while dispatch_req was still high");
            end
        end
        cpl_prev = cpl_valid;
        ack_prev = dispatch_ack;
        req_prev = dispatch_req;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_text($sformatf("timeout, run passed %0d cycles", watchdog_cycles));
    end

    task automatic clear_records();
        for (int i = 0; i < num_tags; i++) begin
            seen_cnt[i] = 0;
        end
        cpl_total = 0;
    endtask

    // full four-phase dispatch, entered and left 2 ns after an edge.
    task automatic do_dispatch(input optype_t op, input word_t a, input word_t b,
                               input ptag_t tag, input rob_num_t rob);
        assert (dispatch_ack == 1'b0)
        else fail_text("dispatch_ack high before a new request");
        dispatch_req = 1'b1;
        dispatch_op = op;
        dispatch_src1 = a;
        dispatch_src2 = b;
        dispatch_tag = tag;
        dispatch_rob = rob;
        // a full queue stalls here.
        do begin
            @(posedge clk);
            #2;
        end while (!dispatch_ack);
        exp_data[tag] = ref_result(op, a, b);
        exp_rob[tag] = rob;
        ack_cycle[tag] = cycle;
        dispatch_req = 1'b0;
        @(posedge clk);
        #2;
        assert (dispatch_ack == 1'b0)
        else fail_text("dispatch_ack did not fall one cycle after dispatch_req fell");
    endtask

    // wait until n completions have been recorded.
    task automatic wait_drained(input int n);
        while (cpl_total < n) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic check_tag(input string name, input int tag);
        assert (seen_cnt[tag] == 1)
        else fail_value($sformatf("%s tag %0d count", name, tag), 1, seen_cnt[tag]);
        assert (got_rob[tag] == exp_rob[tag])
        else fail_value($sformatf("%s tag %0d rob", name, tag), exp_rob[tag], got_rob[tag]);
        assert (got_data[tag] == exp_data[tag])
        else fail_value($sformatf("%s tag %0d data", name, tag), exp_data[tag],
                        got_data[tag]);
        // ack edge to completion is at least four cycles.
        assert (got_cycle[tag] - ack_cycle[tag] >= 4)
        else fail_text($sformatf("%s tag %0d completed %0d cycles after ack", name, tag,
                                 got_cycle[tag] - ack_cycle[tag]));
    endtask

    task automatic test_reset();
        int probe [4];
        probe = '{0, 21, 42, 63};
        assert (dispatch_ack == 1'b0)
        else fail_value("test_reset dispatch_ack", 0, dispatch_ack);
        assert (cpl_valid == 1'b0)
        else fail_value("test_reset cpl_valid", 0, cpl_valid);
        foreach (probe[i]) begin
            rd_tag = ptag_t'(probe[i]);
            #1;
            assert (rd_data == '0)
            else fail_value($sformatf("test_reset rd tag %0d", probe[i]), 0, rd_data);
        end
    endtask

    task automatic test_each_op();
        word_t a;
        word_t b;
        // negative a, shift amount in the low 5 bits of b.
        a = 32'h8000_00f6;
        b = 32'h0000_0f23;
        clear_records();
        for (int i = 0; i < 8; i++) begin
            do_dispatch(optype_t'(i), a, b, ptag_t'(i + 1), rob_num_t'(16'h0100 + i));
        end
        wait_drained(8);
        for (int i = 0; i < 8; i++) begin
            check_tag("test_each_op", i + 1);
        end
    endtask

    task automatic test_handshake();
        int rises_before;
        logic [31:0] r;
        clear_records();
        rises_before = ack_rises;
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            do_dispatch(optype_t'(r[2:0]), lcg_next(), lcg_next(), ptag_t'(9 + i),
                        rob_num_t'(r[31:16]));
        end
        wait_drained(4);
        assert (ack_rises - rises_before == 4)
        else fail_value("test_handshake ack rises", 4, ack_rises - rises_before);
        for (int i = 0; i < 4; i++) begin
            check_tag("test_handshake", 9 + i);
        end
    endtask

    task automatic test_burst();
        logic [31:0] r;
        clear_records();
        // back to back, so the queue fills and alus contend.
        for (int i = 0; i < burst_len; i++) begin
            r = lcg_next();
            do_dispatch(optype_t'(r[2:0]), lcg_next(), lcg_next(),
                        ptag_t'(burst_base + i), rob_num_t'(r[31:16]));
        end
        wait_drained(burst_len);
        // stray completions would show up here.
        repeat (10) @(posedge clk);
        #2;
        assert (cpl_total == burst_len)
        else fail_value("test_burst completions", burst_len, cpl_total);
        for (int i = 0; i < burst_len; i++) begin
            check_tag("test_burst", burst_base + i);
        end
    endtask

    task automatic test_regfile_readback();
        int tag;
        for (int i = 0; i < burst_len; i++) begin
            tag = burst_base + i;
            rd_tag = ptag_t'(tag);
            #1;
            assert (rd_data == exp_data[tag])
            else fail_value($sformatf("test_regfile_readback tag %0d", tag), exp_data[tag],
                            rd_data);
        end
    endtask

    initial begin
        rstn = 1'b0;
        dispatch_req = 1'b0;
        dispatch_op = op_add;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_tag = '0;
        dispatch_rob = '0;
        rd_tag = '0;
        cycle = 0;
        cpl_total = 0;
        ack_rises = 0;
        cpl_prev = 1'b0;
        ack_prev = 1'b0;
        req_prev = 1'b0;
        for (int i = 0; i < num_tags; i++) begin
            seen_cnt[i] = 0;
        end
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        test_reset();
        test_each_op();
        test_handshake();
        test_burst();
        test_regfile_readback();
        $display("Test OK");
        $finish;
    end

endmodule

//--- logic/exec_cluster.sv
`timescale 1ns/1ns

module exec_cluster
    import isa_pkg::*;
    import cluster_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     dispatch_req,
    input  optype_t  dispatch_op,
    input  word_t    dispatch_src1,
    input  word_t    dispatch_src2,
    input  ptag_t    dispatch_tag,
    input  rob_num_t dispatch_rob,
    input  ptag_t    rd_tag,
    output logic     dispatch_ack,
    output logic     cpl_valid,
    output ptag_t    cpl_tag,
    output rob_num_t cpl_rob,
    output word_t    cpl_data,
    output word_t    rd_data
);

    // queue to alus.
    logic [num_alu-1:0] fu_ready;
    logic [num_alu-1:0] issue_valid;
    optype_t            issue_op;
    word_t              issue_src1;
    word_t              issue_src2;
    ptag_t              issue_tag;
    rob_num_t           issue_rob;

    // alus to arbiter.
    logic [num_alu-1:0] wb_req;
    logic [num_alu-1:0] wb_ack;
    word_t              wb_data [num_alu];
    ptag_t              wb_tag [num_alu];
    rob_num_t           wb_rob [num_alu];

    // arbiter to register file.
    logic  wr_en;
    ptag_t wr_tag;
    word_t wr_data;

    issue_queue u_iq (
        .clk(clk),
        .rstn(rstn),
        .dispatch_req(dispatch_req),
        .dispatch_op(dispatch_op),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_tag(dispatch_tag),
        .dispatch_rob(dispatch_rob),
        .fu_ready(fu_ready),
        .dispatch_ack(dispatch_ack),
        .issue_valid(issue_valid),
        .issue_op(issue_op),
        .issue_src1(issue_src1),
        .issue_src2(issue_src2),
        .issue_tag(issue_tag),
        .issue_rob(issue_rob)
    );

    // peer alus on the shared issue bus.
    for (genvar i = 0; i < num_alu; i++) begin : g_alu
        alu_unit u_alu (
            .clk(clk),
            .rstn(rstn),
            .issue_valid(issue_valid[i]),
            .issue_op(issue_op),
            .issue_src1(issue_src1),
            .issue_src2(issue_src2),
            .issue_tag(issue_tag),
            .issue_rob(issue_rob),
            .wb_ack(wb_ack[i]),
            .fu_ready(fu_ready[i]),
            .wb_req(wb_req[i]),
            .wb_data(wb_data[i]),
            .wb_tag(wb_tag[i]),
            .wb_rob(wb_rob[i])
        );
    end

    complete_arbiter u_arb (
        .clk(clk),
        .rstn(rstn),
        .wb_req(wb_req),
        .wb_data(wb_data),
        .wb_tag(wb_tag),
        .wb_rob(wb_rob),
        .wb_ack(wb_ack),
        .wr_en(wr_en),
        .wr_tag(wr_tag),
        .wr_data(wr_data),
        .cpl_valid(cpl_valid),
        .cpl_tag(cpl_tag),
        .cpl_rob(cpl_rob),
        .cpl_data(cpl_data)
    );

    phys_regfile u_prf (
        .clk(clk),
        .rstn(rstn),
        .wr_en(wr_en),
        .wr_tag(wr_tag),
        .wr_data(wr_data),
        .rd_tag(rd_tag),
        .rd_data(rd_data)
    );

endmodule

//--- logic/phys_regfile.sv
`timescale 1ns/1ns

module phys_regfile
    import isa_pkg::*;
    import cluster_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  wr_en,
    input  ptag_t wr_tag,
    input  word_t wr_data,
    input  ptag_t rd_tag,
    output word_t rd_data
);

    // one register per physical tag.
    word_t regs [2**$bits(ptag_t)];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 2**$bits(ptag_t); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_tag] <= wr_data;
        end
    end

    // read port, no bypass.
    assign rd_data = regs[rd_tag];

endmodule

//--- logic/complete_arbiter.sv
`timescale 1ns/1ns

module complete_arbiter
    import isa_pkg::*;
    import cluster_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic [num_alu-1:0] wb_req,
    input  word_t              wb_data [num_alu],
    input  ptag_t              wb_tag [num_alu],
    input  rob_num_t           wb_rob [num_alu],
    output logic [num_alu-1:0] wb_ack,
    output logic               wr_en,
    output ptag_t              wr_tag,
    output word_t              wr_data,
    output logic               cpl_valid,
    output ptag_t              cpl_tag,
    output rob_num_t           cpl_rob,
    output word_t              cpl_data
);

    arb_state_t state;

    // last granted alu, also the one being released.
    alu_sel_t last_q;

    logic     pick_found;
    alu_sel_t pick_sel;

    // granted result.
    logic     fire_q;
    ptag_t    tag_q;
    word_t    data_q;
    rob_num_t rob_q;

    // round robin search from the alu after the last grant.
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_sel = '0;
        for (int k = 1; k <= num_alu; k++) begin
            idx = (int'(last_q) + k) % num_alu;
            if (!pick_found && wb_req[idx]) begin
                pick_found = 1'b1;
                pick_sel = alu_sel_t'(idx);
            end
        end
    end

    // write port and completion share one pulse.
    assign wr_en = fire_q;
    assign wr_tag = tag_q;
    assign wr_data = data_q;
    assign cpl_valid = fire_q;
    assign cpl_tag = tag_q;
    assign cpl_rob = rob_q;
    assign cpl_data = data_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= arb_idle;
            last_q <= alu_sel_t'(num_alu - 1);
            wb_ack <= '0;
            fire_q <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (pick_found) begin
                        wb_ack[pick_sel] <= 1'b1;
                        fire_q <= 1'b1;
                        last_q <= pick_sel;
                        state <= arb_ack;
                    end
                end
                arb_ack: begin
                    // write lasts one cycle.
                    fire_q <= 1'b0;
                    state <= arb_release;
                end
                arb_release: begin
                    // drop ack once the owner has let go.
                    if (!wb_req[last_q]) begin
                        wb_ack <= '0;
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == arb_idle && pick_found) begin
            tag_q <= wb_tag[pick_sel];
            data_q <= wb_data[pick_sel];
            rob_q <= wb_rob[pick_sel];
        end
    end

    // a single open write-back at any time.
    assert property (@(posedge clk) disable iff (!rstn) $onehot0(wb_ack));

endmodule

//--- logic/alu_unit.sv
`timescale 1ns/1ns

module alu_unit
    import isa_pkg::*;
    import cluster_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,
    input  logic     issue_valid,
    input  optype_t  issue_op,
    input  word_t    issue_src1,
    input  word_t    issue_src2,
    input  ptag_t    issue_tag,
    input  rob_num_t issue_rob,
    input  logic     wb_ack,
    output logic     fu_ready,
    output logic     wb_req,
    output word_t    wb_data,
    output ptag_t    wb_tag,
    output rob_num_t wb_rob
);

    alu_state_t state;

    // captured operation.
    optype_t  op_r;
    word_t    src1_r;
    word_t    src2_r;
    word_t    result;
    ptag_t    issue_tag_r;
    rob_num_t issue_rob_r;

    assign fu_ready = (state == alu_idle);

    // tag and rob stay put until the next issue.
    assign wb_tag = issue_tag_r;
    assign wb_rob = issue_rob_r;

    // integer datapath.
    always_comb begin
        case (op_r)
            op_add: result = src1_r + src2_r;
            op_sub: result = src1_r - src2_r;
            op_and: result = src1_r & src2_r;
            op_or: result = src1_r | src2_r;
            op_xor: result = src1_r ^ src2_r;
            op_sll: result = src1_r << src2_r[$clog2(xlen)-1:0];
            op_srl: result = src1_r >> src2_r[$clog2(xlen)-1:0];
            // signed compare.
            op_slt: result = word_t'($signed(src1_r) < $signed(src2_r));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= alu_idle;
            wb_req <= 1'b0;
        end else begin
            case (state)
                alu_idle: begin
                    if (issue_valid) begin
                        state <= alu_exec;
                    end
                end
                alu_exec: begin
                    state <= alu_req;
                end
                alu_req: begin
                    // raise req, then hold it until granted.
                    if (!wb_req) begin
                        wb_req <= 1'b1;
                    end else if (wb_ack) begin
                        wb_req <= 1'b0;
                        state <= alu_wait_release;
                    end
                end
                alu_wait_release: begin
                    if (!wb_ack) begin
                        state <= alu_idle;
                    end
                end
                default: state <= alu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == alu_idle && issue_valid) begin
            op_r <= issue_op;
            src1_r <= issue_src1;
            src2_r <= issue_src2;
            issue_tag_r <= issue_tag;
            issue_rob_r <= issue_rob;
        end
        // result registered one edge after issue.
        if (state == alu_exec) begin
            wb_data <= result;
        end
    end

    // the arbiter must have acked before req may drop.
    assert property (@(posedge clk) disable iff (!rstn) $fell(wb_req) |-> $past(wb_ack));

endmodule

//--- logic/issue_queue.sv
`timescale 1ns/1ns

module issue_queue
    import isa_pkg::*;
    import cluster_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               dispatch_req,
    input  optype_t            dispatch_op,
    input  word_t              dispatch_src1,
    input  word_t              dispatch_src2,
    input  ptag_t              dispatch_tag,
    input  rob_num_t           dispatch_rob,
    input  logic [num_alu-1:0] fu_ready,
    output logic               dispatch_ack,
    output logic [num_alu-1:0] issue_valid,
    output optype_t            issue_op,
    output word_t              issue_src1,
    output word_t              issue_src2,
    output ptag_t              issue_tag,
    output rob_num_t           issue_rob
);

    // entry payload.
    optype_t  op_q   [iq_depth];
    word_t    src1_q [iq_depth];
    word_t    src2_q [iq_depth];
    ptag_t    tag_q  [iq_depth];
    rob_num_t rob_q  [iq_depth];

    iq_ptr_t head;
    iq_ptr_t tail;
    logic [$clog2(iq_depth):0] count;

    logic     full;
    logic     push;
    logic     pop;
    logic     pick_found;
    alu_sel_t pick_sel;

    assign full = (count == iq_depth);

    // new entry only on a fresh request with ack low.
    assign push = dispatch_req && !dispatch_ack && !full;

    // lowest numbered idle alu wins.
    always_comb begin
        pick_found = 1'b0;
        pick_sel = '0;
        for (int i = 0; i < num_alu; i++) begin
            if (!pick_found && fu_ready[i]) begin
                pick_found = 1'b1;
                pick_sel = alu_sel_t'(i);
            end
        end
    end

    // head leaves when an alu takes it.
    assign pop = pick_found && (count != '0);

    always_comb begin
        issue_valid = '0;
        issue_valid[pick_sel] = pop;
    end

    // oldest entry on the shared issue bus.
    assign issue_op   = op_q[head];
    assign issue_src1 = src1_q[head];
    assign issue_src2 = src2_q[head];
    assign issue_tag  = tag_q[head];
    assign issue_rob  = rob_q[head];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            dispatch_ack <= 1'b0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // ack held until the source lets go of req.
            if (push) begin
                dispatch_ack <= 1'b1;
            end else if (dispatch_ack && !dispatch_req) begin
                dispatch_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[tail] <= dispatch_op;
            src1_q[tail] <= dispatch_src1;
            src2_q[tail] <= dispatch_src2;
            tag_q[tail] <= dispatch_tag;
            rob_q[tail] <= dispatch_rob;
        end
    end

    // nothing issues from an empty queue.
    assert property (@(posedge clk) disable iff (!rstn) (count == '0) |-> (issue_valid == '0));

    // one alu per cycle at most.
    assert property (@(posedge clk) disable iff (!rstn) $onehot0(issue_valid));

    // no acceptance into a full queue.
    assert property (@(posedge clk) disable iff (!rstn)
        $rose(dispatch_ack) |-> ($past(count) < iq_depth));

endmodule

//--- logic/cluster_pkg.sv
package cluster_pkg;

    // peer alus sharing the write port.
    localparam int num_alu = 3;
    // issue queue entries.
    localparam int iq_depth = 4;

    // physical register tag, 64 registers.
    typedef logic [5:0] ptag_t;
    // rob number as carried by the core.
    typedef logic [15:0] rob_num_t;
    // alu index.
    typedef logic [1:0] alu_sel_t;
    // queue pointer, wraps at iq_depth.
    typedef logic [1:0] iq_ptr_t;

    // per-alu control.
    typedef enum logic [1:0] {
        alu_idle,
        alu_exec,
        alu_req,
        alu_wait_release
    } alu_state_t;

    // completion arbiter control.
    typedef enum logic [1:0] {
        arb_idle,
        arb_ack,
        arb_release
    } arb_state_t;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

    // data path width of the integer subset.
    localparam int xlen = 32;

    // operand and result word.
    typedef logic [xlen-1:0] word_t;

    // alu operation codes.
    // shifts take the low bits of operand 2 only.
    // slt compares signed and returns 1 or 0.
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6,
        op_slt = 4'd7
    } optype_t;

endpackage
